/* src/dnc_shape_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Matrix dimension limits for the DNC read vector block
// Run-time size type and the buffer address types
//////////////////////////////////////////////////////////////////////

package dnc_shape_pkg;

  //////////////////////////////////////////////////////////////////////
  // Dimension limits
  //////////////////////////////////////////////////////////////////////

  // Memory rows, word width, read heads
  localparam int N_MAX = 8;
  localparam int W_MAX = 4;
  localparam int R_MAX = 2;

  // Buffer depths, one slot per element at full size
  localparam int M_DEPTH = N_MAX * W_MAX;
  localparam int W_DEPTH = R_MAX * N_MAX;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // Run-time dimension, 1 up to the limits above
  typedef logic [3:0] size_t;

  // Memory location: row j times W_MAX plus k
  typedef logic [$clog2(M_DEPTH)-1:0] m_addr_t;

  // Weight location: head i times N_MAX plus j
  typedef logic [$clog2(W_DEPTH)-1:0] w_addr_t;

endpackage

/* src/dnc_fixed_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Fixed-point formats of memory words, weights and accumulator
// Saturation limits and rounding constant of the result
//////////////////////////////////////////////////////////////////////

package dnc_fixed_pkg;

  //////////////////////////////////////////////////////////////////////
  // Operand and result formats
  //////////////////////////////////////////////////////////////////////

  // Signed Q4.12, also used for every read vector element
  typedef logic signed [15:0] mem_word_t;

  // Unsigned Q0.16
  typedef logic [15:0] weight_t;

  // Fraction bits dropped after the sum
  localparam int WEIGHT_FRAC = 16;

  // Room for N_MAX products of 32 bits plus sign
  typedef logic signed [39:0] acc_t;

  // Clamp range of mem_word_t
  localparam mem_word_t MEM_MAX = mem_word_t'(16'h7FFF);
  localparam mem_word_t MEM_MIN = mem_word_t'(16'h8000);

  // Half an output LSB, added before the shift
  localparam acc_t ROUND_HALF = acc_t'(2 ** (WEIGHT_FRAC - 1));

endpackage

/* src/dnc_matrix_buffer.sv */
//////////////////////////////////////////////////////////////////////
// Single-port-write, single-port-read storage for one matrix
// Element type is a parameter, read data is registered
//////////////////////////////////////////////////////////////////////

module dnc_matrix_buffer #(
  parameter type elem_t = logic [15:0],
  parameter int  DEPTH  = dnc_shape_pkg::M_DEPTH
) (
  input  logic                     CLK,

  // Write side, one word per cycle
  input  logic                     WR_EN,
  input  logic [$clog2(DEPTH)-1:0] WR_ADDR,
  input  elem_t                    WR_DATA,

  // Read side, data one cycle after address
  input  logic [$clog2(DEPTH)-1:0] RD_ADDR,
  output elem_t                    RD_DATA
);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  // One slot per element at full size
  elem_t mem [DEPTH];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // Loaded in stream order by the controller
  always_ff @(posedge CLK) begin
    if (WR_EN) begin
      mem[WR_ADDR] <= WR_DATA;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // Registered read
  // Address may jump anywhere, the controller walks it in transposed order
  always_ff @(posedge CLK) begin
    RD_DATA <= mem[RD_ADDR];
  end

endmodule

/* src/dnc_mac_unit.sv */
//////////////////////////////////////////////////////////////////////
// Pipelined multiply-accumulate for the read vectors
// Round half up and saturation of each finished sum
//////////////////////////////////////////////////////////////////////

module dnc_mac_unit (
  input  logic                    CLK,
  input  logic                    RST,

  // Operands, aligned with buffer read data
  input  logic                    OP_VALID,
  input  logic                    OP_FIRST,
  input  logic                    OP_LAST,
  input  dnc_fixed_pkg::mem_word_t MEM_WORD,
  input  dnc_fixed_pkg::weight_t   WEIGHT,

  // Finished results
  output dnc_fixed_pkg::mem_word_t R_OUT,
  output logic                    R_OUT_ENABLE,

  // Run completion
  input  logic                    DONE_LAST,
  output logic                    DONE
);

  import dnc_fixed_pkg::*;

  // Product stage
  acc_t prod_q;
  logic prod_valid_q;
  logic prod_first_q;
  logic prod_last_q;
  logic prod_done_q;

  // Accumulate stage
  acc_t acc_q;
  acc_t sum;
  acc_t rounded;
  mem_word_t clamped;

  //////////////////////////////////////////////////////////////////////
  // Stage 1, multiply
  //////////////////////////////////////////////////////////////////////

  // Weight widened with a zero sign bit, so the product stays signed
  always_ff @(posedge CLK) begin
    prod_q <= MEM_WORD * $signed({1'b0, WEIGHT});
  end

  // Flags follow the product
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prod_valid_q <= 1'b0;
      prod_first_q <= 1'b0;
      prod_last_q  <= 1'b0;
      prod_done_q  <= 1'b0;
    end else begin
      prod_valid_q <= OP_VALID;
      prod_first_q <= OP_FIRST;
      prod_last_q  <= OP_LAST;
      prod_done_q  <= DONE_LAST;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2, accumulate, round, clamp
  //////////////////////////////////////////////////////////////////////

  // First operand restarts the sum
  assign sum = prod_first_q ? prod_q : acc_q + prod_q;

  // Half up, then drop the weight fraction
  assign rounded = (sum + ROUND_HALF) >>> WEIGHT_FRAC;

  always_comb begin
    if (rounded > acc_t'(MEM_MAX)) begin
      clamped = MEM_MAX;
    end else if (rounded < acc_t'(MEM_MIN)) begin
      clamped = MEM_MIN;
    end else begin
      clamped = mem_word_t'(rounded);
    end
  end

  // Accumulator and result register
  always_ff @(posedge CLK) begin
    if (prod_valid_q) begin
      acc_q <= sum;
    end
    if (prod_valid_q && prod_last_q) begin
      R_OUT <= clamped;
    end
  end

  // One pulse per result, DONE on the final one
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      R_OUT_ENABLE <= 1'b0;
      DONE         <= 1'b0;
    end else begin
      R_OUT_ENABLE <= prod_valid_q && prod_last_q;
      DONE         <= prod_valid_q && prod_last_q && prod_done_q;
    end
  end

endmodule

/* src/dnc_read_controller.sv */
//////////////////////////////////////////////////////////////////////
// Controller of the read vector block
// FSM, load counters, transposed-order fetch and completion
//////////////////////////////////////////////////////////////////////

module dnc_read_controller (
  input  logic                     CLK,
  input  logic                     RST,

  // Run control and sizes
  input  logic                     START,
  input  dnc_shape_pkg::size_t     SIZE_R_IN,
  input  dnc_shape_pkg::size_t     SIZE_N_IN,
  input  dnc_shape_pkg::size_t     SIZE_W_IN,

  // Source streams
  input  dnc_fixed_pkg::mem_word_t M_IN,
  input  logic                     M_IN_ENABLE,
  input  dnc_fixed_pkg::weight_t   W_IN,
  input  logic                     W_IN_ENABLE,

  // Buffer write ports
  output logic                     M_WR_EN,
  output dnc_shape_pkg::m_addr_t   M_WR_ADDR,
  output dnc_fixed_pkg::mem_word_t M_WR_DATA,
  output logic                     W_WR_EN,
  output dnc_shape_pkg::w_addr_t   W_WR_ADDR,
  output dnc_fixed_pkg::weight_t   W_WR_DATA,

  // Buffer read addresses
  output dnc_shape_pkg::m_addr_t   M_RD_ADDR,
  output dnc_shape_pkg::w_addr_t   W_RD_ADDR,

  // MAC side
  output logic                     OP_VALID,
  output logic                     OP_FIRST,
  output logic                     OP_LAST,
  output logic                     DONE_LAST,
  input  logic                     MAC_DONE,
  output logic                     READY
);

  import dnc_shape_pkg::*;

  typedef enum logic [1:0] {
    idle_st,
    load_st,
    compute_st,
    drain_st
  } state_t;

  state_t state;

  // Last index of each dimension, sampled at START
  size_t r_last;
  size_t n_last;
  size_t w_last;

  // Load counters, memory j/k and weight i/j
  size_t m_j;
  size_t m_k;
  size_t w_i;
  size_t w_j;
  logic  m_done;
  logic  w_done;
  logic  m_take;
  logic  w_take;

  // Compute counters, head i, column k, row j
  size_t c_i;
  size_t c_k;
  size_t c_j;
  logic  fetch_last;
  logic  fetch_final;

  assign m_take = (state == load_st) && M_IN_ENABLE && !m_done;
  assign w_take = (state == load_st) && W_IN_ENABLE && !w_done;

  assign fetch_last  = (c_j == n_last);
  assign fetch_final = fetch_last && (c_k == w_last) && (c_i == r_last);

  // Transpose by walking M down column k
  assign M_RD_ADDR = m_addr_t'(c_j * W_MAX + c_k);
  assign W_RD_ADDR = w_addr_t'(c_i * N_MAX + c_j);

  //////////////////////////////////////////////////////////////////////
  // FSM and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= idle_st;
      r_last <= '0;
      n_last <= '0;
      w_last <= '0;
      m_j    <= '0;
      m_k    <= '0;
      w_i    <= '0;
      w_j    <= '0;
      m_done <= 1'b0;
      w_done <= 1'b0;
      c_i    <= '0;
      c_k    <= '0;
      c_j    <= '0;
      READY  <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (state)
        idle_st: begin
          // START elsewhere is ignored
          if (START) begin
            r_last <= SIZE_R_IN - size_t'(1);
            n_last <= SIZE_N_IN - size_t'(1);
            w_last <= SIZE_W_IN - size_t'(1);
            m_j    <= '0;
            m_k    <= '0;
            w_i    <= '0;
            w_j    <= '0;
            m_done <= 1'b0;
            w_done <= 1'b0;
            c_i    <= '0;
            c_k    <= '0;
            c_j    <= '0;
            state  <= load_st;
          end
        end
        load_st: begin
          // Memory words, k inner
          if (m_take) begin
            if (m_k == w_last) begin
              m_k <= '0;
              if (m_j == n_last) m_done <= 1'b1;
              else m_j <= m_j + size_t'(1);
            end else begin
              m_k <= m_k + size_t'(1);
            end
          end
          // Weights, j inner
          if (w_take) begin
            if (w_j == n_last) begin
              w_j <= '0;
              if (w_i == r_last) w_done <= 1'b1;
              else w_i <= w_i + size_t'(1);
            end else begin
              w_j <= w_j + size_t'(1);
            end
          end
          // Flags are registered, last write lands before the first read
          if (m_done && w_done) state <= compute_st;
        end
        compute_st: begin
          // One fetch per cycle, j inner, then k, then i
          if (fetch_last) begin
            c_j <= '0;
            if (c_k == w_last) begin
              c_k <= '0;
              if (c_i == r_last) state <= drain_st;
              else c_i <= c_i + size_t'(1);
            end else begin
              c_k <= c_k + size_t'(1);
            end
          end else begin
            c_j <= c_j + size_t'(1);
          end
        end
        drain_st: begin
          // READY one cycle after the final result
          if (MAC_DONE) begin
            READY <= 1'b1;
            state <= idle_st;
          end
        end
        default: state <= idle_st;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Buffer writes and MAC flags
  //////////////////////////////////////////////////////////////////////

  // Stream word goes to its fixed-stride slot
  always_ff @(posedge CLK) begin
    M_WR_ADDR <= m_addr_t'(m_j * W_MAX + m_k);
    M_WR_DATA <= M_IN;
    W_WR_ADDR <= w_addr_t'(w_i * N_MAX + w_j);
    W_WR_DATA <= W_IN;
  end

  // Delayed one cycle to meet the buffer read data
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      M_WR_EN   <= 1'b0;
      W_WR_EN   <= 1'b0;
      OP_VALID  <= 1'b0;
      OP_FIRST  <= 1'b0;
      OP_LAST   <= 1'b0;
      DONE_LAST <= 1'b0;
    end else begin
      M_WR_EN   <= m_take;
      W_WR_EN   <= w_take;
      OP_VALID  <= (state == compute_st);
      OP_FIRST  <= (state == compute_st) && (c_j == '0);
      OP_LAST   <= (state == compute_st) && fetch_last;
      DONE_LAST <= (state == compute_st) && fetch_final;
    end
  end

endmodule

/* src/dnc_read_vectors.sv */
//////////////////////////////////////////////////////////////////////
// DNC read vectors, r(i,k) = sum over j of M(j,k) w(i,j)
// Controller, memory and weight buffers, MAC unit
//////////////////////////////////////////////////////////////////////

module dnc_read_vectors (
  input  logic                     CLK,
  input  logic                     RST,

  // Control
  input  logic                     START,
  output logic                     READY,

  // Sizes, sampled at START
  input  dnc_shape_pkg::size_t     SIZE_R_IN,
  input  dnc_shape_pkg::size_t     SIZE_N_IN,
  input  dnc_shape_pkg::size_t     SIZE_W_IN,

  // Memory stream, row-major
  input  dnc_fixed_pkg::mem_word_t M_IN,
  input  logic                     M_IN_ENABLE,

  // Weight stream, head-major
  input  dnc_fixed_pkg::weight_t   W_IN,
  input  logic                     W_IN_ENABLE,

  // Read vectors, head-major
  output dnc_fixed_pkg::mem_word_t R_OUT,
  output logic                     R_OUT_ENABLE
);

  import dnc_shape_pkg::*;
  import dnc_fixed_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////////////////////////

  // Memory buffer
  logic      m_wr_en;
  m_addr_t   m_wr_addr;
  mem_word_t m_wr_data;
  m_addr_t   m_rd_addr;
  mem_word_t m_rd_data;

  // Weight buffer
  logic      w_wr_en;
  w_addr_t   w_wr_addr;
  weight_t   w_wr_data;
  w_addr_t   w_rd_addr;
  weight_t   w_rd_data;

  // MAC control
  logic op_valid;
  logic op_first;
  logic op_last;
  logic done_last;
  logic mac_done;

  //////////////////////////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////////////////////////

  dnc_read_controller controller (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .SIZE_R_IN   (SIZE_R_IN),
    .SIZE_N_IN   (SIZE_N_IN),
    .SIZE_W_IN   (SIZE_W_IN),
    .M_IN        (M_IN),
    .M_IN_ENABLE (M_IN_ENABLE),
    .W_IN        (W_IN),
    .W_IN_ENABLE (W_IN_ENABLE),
    .M_WR_EN     (m_wr_en),
    .M_WR_ADDR   (m_wr_addr),
    .M_WR_DATA   (m_wr_data),
    .W_WR_EN     (w_wr_en),
    .W_WR_ADDR   (w_wr_addr),
    .W_WR_DATA   (w_wr_data),
    .M_RD_ADDR   (m_rd_addr),
    .W_RD_ADDR   (w_rd_addr),
    .OP_VALID    (op_valid),
    .OP_FIRST    (op_first),
    .OP_LAST     (op_last),
    .DONE_LAST   (done_last),
    .MAC_DONE    (mac_done),
    .READY       (READY)
  );

  // Memory matrix, read back in transposed order
  dnc_matrix_buffer #(
    .elem_t (mem_word_t),
    .DEPTH  (M_DEPTH)
  ) memory_buffer (
    .CLK     (CLK),
    .WR_EN   (m_wr_en),
    .WR_ADDR (m_wr_addr),
    .WR_DATA (m_wr_data),
    .RD_ADDR (m_rd_addr),
    .RD_DATA (m_rd_data)
  );

  // Read weightings
  dnc_matrix_buffer #(
    .elem_t (weight_t),
    .DEPTH  (W_DEPTH)
  ) weight_buffer (
    .CLK     (CLK),
    .WR_EN   (w_wr_en),
    .WR_ADDR (w_wr_addr),
    .WR_DATA (w_wr_data),
    .RD_ADDR (w_rd_addr),
    .RD_DATA (w_rd_data)
  );

  dnc_mac_unit mac_unit (
    .CLK          (CLK),
    .RST          (RST),
    .OP_VALID     (op_valid),
    .OP_FIRST     (op_first),
    .OP_LAST      (op_last),
    .MEM_WORD     (m_rd_data),
    .WEIGHT       (w_rd_data),
    .R_OUT        (R_OUT),
    .R_OUT_ENABLE (R_OUT_ENABLE),
    .DONE_LAST    (done_last),
    .DONE         (mac_done)
  );

endmodule

/* dv/dnc_read_checker.sv */
//////////////////////////////////////////////////////////////////////
// Reference model and result comparison at the DUT ports
// Reports one line per test and keeps the counts
//////////////////////////////////////////////////////////////////////

module dnc_read_checker (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     START,
  input  dnc_shape_pkg::size_t     SIZE_R_IN,
  input  dnc_shape_pkg::size_t     SIZE_N_IN,
  input  dnc_shape_pkg::size_t     SIZE_W_IN,
  input  dnc_fixed_pkg::mem_word_t M_IN,
  input  logic                     M_IN_ENABLE,
  input  dnc_fixed_pkg::weight_t   W_IN,
  input  logic                     W_IN_ENABLE,
  input  dnc_fixed_pkg::mem_word_t R_OUT,
  input  logic                     R_OUT_ENABLE,
  input  logic                     READY,
  output int                       error_count,
  output int                       result_count,
  output int                       test_count
);

  import dnc_shape_pkg::*;
  import dnc_fixed_pkg::*;

  // Set by the testbench before each START
  string test_name = "none";

  logic busy = 1'b0;
  logic prev_enable = 1'b0;
  int   errors = 0;
  int   results = 0;
  int   tests = 0;
  int   run_errors = 0;
  int   size_r;
  int   size_n;
  int   size_w;
  int   m_count;
  int   w_count;
  int   r_index;

  mem_word_t m_store [N_MAX][W_MAX];
  weight_t   w_store [R_MAX][N_MAX];
  mem_word_t expected;

  assign error_count  = errors;
  assign result_count = results;
  assign test_count   = tests;

  // Exact sum, half up, shift by 16, clamp to 16 signed bits
  function automatic mem_word_t model_result(input int i, input int k);
    longint sum;
    longint rounded;
    int     j;
    sum = 0;
    for (j = 0; j < size_n; j++) begin
      sum = sum + longint'(m_store[j][k]) * longint'(w_store[i][j]);
    end
    rounded = (sum + 64'sd32768) >>> 16;
    if (rounded > 64'sd32767) rounded = 64'sd32767;
    else if (rounded < -64'sd32768) rounded = -64'sd32768;
    return mem_word_t'(rounded);
  endfunction

  task automatic report(input string text);
    $display("%s: %s", test_name, text);
    errors     = errors + 1;
    run_errors = run_errors + 1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Port watcher, sampled on the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (RST) begin
      busy = 1'b0;
      if (READY === 1'b1 || R_OUT_ENABLE === 1'b1) report("strobe high during reset");
    end else begin
      // Results, i outer and k inner
      if (R_OUT_ENABLE === 1'b1) begin
        if (!busy || r_index >= size_r * size_w) begin
          report("R_OUT_ENABLE with no result due");
        end else begin
          expected = model_result(r_index / size_w, r_index % size_w);
          if (R_OUT !== expected) begin
            $display("FAILED %s r(%0d,%0d): expected %h actual %h", test_name,
                     r_index / size_w, r_index % size_w, expected, R_OUT);
            errors     = errors + 1;
            run_errors = run_errors + 1;
          end
          r_index = r_index + 1;
          results = results + 1;
        end
      end else if (R_OUT_ENABLE !== 1'b0) begin
        report("R_OUT_ENABLE is unknown");
      end
      // READY ends the run
      if (READY === 1'b1) begin
        if (!busy) begin
          report("READY while idle");
        end else begin
          if (r_index != size_r * size_w) begin
            $display("%s: READY after %0d results, %0d due", test_name, r_index,
                     size_r * size_w);
            errors     = errors + 1;
            run_errors = run_errors + 1;
          end
          if (!prev_enable) report("READY not one cycle after the last result");
          if (run_errors == 0) $display("Test %s passed, %0d results", test_name, r_index);
          else $display("Test %s had %0d errors", test_name, run_errors);
          tests = tests + 1;
          busy  = 1'b0;
        end
      end else if (READY !== 1'b0) begin
        report("READY is unknown");
      end
      // Stream words, only during a run and up to the due count
      if (busy && M_IN_ENABLE === 1'b1 && m_count < size_n * size_w) begin
        m_store[m_count / size_w][m_count % size_w] = M_IN;
        m_count = m_count + 1;
      end
      if (busy && W_IN_ENABLE === 1'b1 && w_count < size_r * size_n) begin
        w_store[w_count / size_n][w_count % size_n] = W_IN;
        w_count = w_count + 1;
      end
      // START counts in idle only
      if (START === 1'b1 && !busy) begin
        busy       = 1'b1;
        size_r     = int'(SIZE_R_IN);
        size_n     = int'(SIZE_N_IN);
        size_w     = int'(SIZE_W_IN);
        m_count    = 0;
        w_count    = 0;
        r_index    = 0;
        run_errors = 0;
      end
      prev_enable = (R_OUT_ENABLE === 1'b1);
    end
  end

endmodule

/* dv/dnc_read_vectors_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench of the DNC read vector block
// Clock, reset, test table, LFSR stimulus, stimulus loop and timeout
//////////////////////////////////////////////////////////////////////

module dnc_read_vectors_tb;

  import dnc_shape_pkg::*;
  import dnc_fixed_pkg::*;

  localparam int NUM_TESTS  = 10;
  localparam int RST_CYCLES = 5;

  // Data modes of the table
  localparam int MODE_RANDOM   = 0;
  localparam int MODE_SAT_HIGH = 1;
  localparam int MODE_SAT_LOW  = 2;
  localparam int MODE_ROUND    = 3;
  localparam int MODE_DIRECTED = 4;

  logic      CLK;
  logic      RST;
  logic      start;
  logic      ready;
  size_t     size_r;
  size_t     size_n;
  size_t     size_w;
  mem_word_t m_in;
  logic      m_in_enable;
  weight_t   w_in;
  logic      w_in_enable;
  mem_word_t r_out;
  logic      r_out_enable;

  int error_count;
  int result_count;
  int test_count;

  // Test table, one entry per row
  string tab_name [NUM_TESTS];
  int    tab_r    [NUM_TESTS];
  int    tab_n    [NUM_TESTS];
  int    tab_w    [NUM_TESTS];
  int    tab_mode [NUM_TESTS];
  int    tab_gap  [NUM_TESTS];
  int    tab_busy [NUM_TESTS];

  logic [31:0] lfsr_state;
  logic        timer_on;
  int          cycle_count;
  int          cycle_limit;

  dnc_read_vectors uut (
    .CLK          (CLK),
    .RST          (RST),
    .START        (start),
    .READY        (ready),
    .SIZE_R_IN    (size_r),
    .SIZE_N_IN    (size_n),
    .SIZE_W_IN    (size_w),
    .M_IN         (m_in),
    .M_IN_ENABLE  (m_in_enable),
    .W_IN         (w_in),
    .W_IN_ENABLE  (w_in_enable),
    .R_OUT        (r_out),
    .R_OUT_ENABLE (r_out_enable)
  );

  dnc_read_checker check (
    .CLK          (CLK),
    .RST          (RST),
    .START        (start),
    .SIZE_R_IN    (size_r),
    .SIZE_N_IN    (size_n),
    .SIZE_W_IN    (size_w),
    .M_IN         (m_in),
    .M_IN_ENABLE  (m_in_enable),
    .W_IN         (w_in),
    .W_IN_ENABLE  (w_in_enable),
    .R_OUT        (r_out),
    .R_OUT_ENABLE (r_out_enable),
    .READY        (ready),
    .error_count  (error_count),
    .result_count (result_count),
    .test_count   (test_count)
  );

  //////////////////////////////////////////////////////////////////////
  // Clock
  //////////////////////////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Test table and random source
  //////////////////////////////////////////////////////////////////////

  task automatic set_row(input int t, input string name, input int r, input int n,
                         input int w, input int mode, input int gap, input int busy);
    tab_name[t] = name;
    tab_r[t]    = r;
    tab_n[t]    = n;
    tab_w[t]    = w;
    tab_mode[t] = mode;
    tab_gap[t]  = gap;
    tab_busy[t] = busy;
  endtask

  task automatic fill_table();
    set_row(0, "full_random", 2, 8, 4, MODE_RANDOM, 0, 0);
    set_row(1, "reduced_3x2", 1, 3, 2, MODE_RANDOM, 0, 0);
    set_row(2, "single_1x1", 1, 1, 1, MODE_RANDOM, 0, 0);
    set_row(3, "saturate_high", 2, 8, 4, MODE_SAT_HIGH, 0, 0);
    set_row(4, "saturate_low", 2, 8, 4, MODE_SAT_LOW, 0, 0);
    set_row(5, "round_half_up", 2, 5, 4, MODE_ROUND, 0, 0);
    set_row(6, "gaps_full", 2, 8, 4, MODE_RANDOM, 1, 0);
    set_row(7, "gaps_reduced", 1, 3, 2, MODE_RANDOM, 1, 0);
    set_row(8, "directed_select", 2, 8, 4, MODE_DIRECTED, 0, 0);
    set_row(9, "busy_start", 2, 8, 4, MODE_RANDOM, 0, 1);
  endtask

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int count, output logic [15:0] value);
    logic [15:0] acc;
    int          b;
    acc = '0;
    for (b = 0; b < count; b++) begin
      acc        = {acc[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    value = acc;
  endtask

  task automatic make_mem_word(input int mode, input int j, input int k, output mem_word_t word);
    logic [15:0] bits;
    case (mode)
      // Close to +8.0 and -8.0
      MODE_SAT_HIGH: begin
        take_bits(8, bits);
        word = mem_word_t'(16'h7F00 | bits);
      end
      MODE_SAT_LOW: begin
        take_bits(8, bits);
        word = mem_word_t'(16'h8000 | bits);
      end
      // Odd raw values, negative on odd columns
      MODE_ROUND: word = (k % 2 == 1) ? mem_word_t'(-(2 * j + 1)) : mem_word_t'(2 * j + 1);
      MODE_DIRECTED: word = mem_word_t'((j * W_MAX + k) << 8);
      default: begin
        take_bits(16, bits);
        word = mem_word_t'(bits);
      end
    endcase
  endtask

  task automatic make_weight(input int mode, input int i, input int j, output weight_t weight);
    logic [15:0] bits;
    case (mode)
      // Weights just under one
      MODE_SAT_HIGH, MODE_SAT_LOW: begin
        take_bits(8, bits);
        weight = weight_t'(16'hFF00 | bits);
      end
      // Half, so every odd sum lands on half an LSB
      MODE_ROUND: weight = 16'h8000;
      // Head i picks row i
      MODE_DIRECTED: weight = (j == i) ? 16'hFFFF : 16'h0000;
      default: take_bits(16, weight);
    endcase
  endtask

  function automatic int row_budget(input int t);
    int loads;
    int products;
    loads    = tab_n[t] * tab_w[t] + tab_r[t] * tab_n[t];
    products = tab_r[t] * tab_n[t] * tab_w[t];
    return 3 * loads + products + 20;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // One table row
  //////////////////////////////////////////////////////////////////////

  task automatic run_row(input int t);
    int          m_total;
    int          w_total;
    int          m_sent;
    int          w_sent;
    logic        m_idle;
    logic        w_idle;
    logic        send_m;
    logic        send_w;
    logic [15:0] bit_val;
    mem_word_t   m_word;
    weight_t     w_word;
    m_total = tab_n[t] * tab_w[t];
    w_total = tab_r[t] * tab_n[t];
    check.test_name = tab_name[t];
    // Stray strobes while idle must be dropped
    if (tab_gap[t] != 0) begin
      m_in        = 16'h5A5A;
      w_in        = 16'hA5A5;
      m_in_enable = 1'b1;
      w_in_enable = 1'b1;
      @(negedge CLK);
      m_in_enable = 1'b0;
      w_in_enable = 1'b0;
    end
    size_r = size_t'(tab_r[t]);
    size_n = size_t'(tab_n[t]);
    size_w = size_t'(tab_w[t]);
    start  = 1'b1;
    @(negedge CLK);
    start  = 1'b0;
    m_sent = 0;
    w_sent = 0;
    m_idle = 1'b0;
    w_idle = 1'b0;
    while (m_sent < m_total || w_sent < w_total) begin
      if (tab_gap[t] != 0) begin
        // Both streams at once, never two idle cycles in a row
        take_bits(1, bit_val);
        send_m = (m_sent < m_total) && (bit_val[0] || m_idle);
        take_bits(1, bit_val);
        send_w = (w_sent < w_total) && (bit_val[0] || w_idle);
      end else begin
        // Memory first, then weights, back to back
        send_m = (m_sent < m_total);
        send_w = !send_m && (w_sent < w_total);
      end
      m_idle = (m_sent < m_total) && !send_m;
      w_idle = (w_sent < w_total) && !send_w;
      m_in_enable = send_m;
      w_in_enable = send_w;
      if (send_m) begin
        make_mem_word(tab_mode[t], m_sent / tab_w[t], m_sent % tab_w[t], m_word);
        m_in   = m_word;
        m_sent = m_sent + 1;
      end
      if (send_w) begin
        make_weight(tab_mode[t], w_sent / tab_n[t], w_sent % tab_n[t], w_word);
        w_in   = w_word;
        w_sent = w_sent + 1;
      end
      @(negedge CLK);
    end
    m_in_enable = 1'b0;
    w_in_enable = 1'b0;
    // Second START deep in compute, other sizes on the bus
    if (tab_busy[t] != 0) begin
      repeat (4) @(negedge CLK);
      size_r = size_t'(1);
      size_n = size_t'(1);
      size_w = size_t'(1);
      start  = 1'b1;
      @(negedge CLK);
      start  = 1'b0;
    end
    while (ready !== 1'b1) @(negedge CLK);
    @(negedge CLK);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    RST         = 1'b1;
    start       = 1'b0;
    size_r      = '0;
    size_n      = '0;
    size_w      = '0;
    m_in        = '0;
    m_in_enable = 1'b0;
    w_in        = '0;
    w_in_enable = 1'b0;
    timer_on    = 1'b0;
    cycle_count = 0;
    lfsr_state  = 32'd74182;
    fill_table();
    cycle_limit = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      cycle_limit = cycle_limit + row_budget(t);
    end
    repeat (RST_CYCLES) @(negedge CLK);
    RST      = 1'b0;
    timer_on = 1'b1;
    // Quiet cycles, the checker watches READY and R_OUT_ENABLE stay low
    repeat (3) @(negedge CLK);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_row(t);
    end
    repeat (2) @(negedge CLK);
    $display("Summary: %0d of %0d tests run, %0d results checked, %0d errors",
             test_count, NUM_TESTS, result_count, error_count);
    if (error_count == 0 && test_count == NUM_TESTS) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Run limit from the table
  initial begin
    wait (timer_on);
    while (cycle_count < cycle_limit) begin
      @(posedge CLK);
      cycle_count = cycle_count + 1;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Something failed");
    $finish;
  end

endmodule

/* dnc_read_vectors.f */
src/dnc_shape_pkg.sv
src/dnc_fixed_pkg.sv
src/dnc_matrix_buffer.sv
src/dnc_mac_unit.sv
src/dnc_read_controller.sv
src/dnc_read_vectors.sv
dv/dnc_read_checker.sv
dv/dnc_read_vectors_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary -Wno-fatal -j 0
TOP       = dnc_read_vectors_tb
FILELIST  = dnc_read_vectors.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Something failed" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
